// ==== Makefile ====
# Verilator simulation of the output-clock post-processing chain

TOP := tb_ppu_out

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f verilog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// ==== hw/limit_rgb_stage.sv ====
/*
 * Limited-range RGB conversion in three pipeline steps, with the
 * full-range color and sync delayed alongside
 */
`timescale 1ns/1ps
`default_nettype none

module limit_rgb_stage
  import ppu_pkg::*;
(
  input  logic   VCLK_Tx,
  input  logic   nVRST_Tx,
  input  video_t video_i,
  input  logic   limited_rgb_i,
  output video_t video_o
);

  // Index 2 is red, 0 is blue
  color_t [2:0]        ch_in;
  logic   [2:0][15:0]  prod;
  logic   [2:0][8:0]   scaled_q;
  color_t [2:0]        rounded_q;
  color_t [2:0]        ch_lim;
  rgb_t                rgb_lim;

  // Unmodified stream two cycles behind the input
  video_t vid_d1;
  video_t vid_d2;

  assign ch_in   = video_i.rgb;
  assign rgb_lim = ch_lim;

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      prod[i]   = ch_in[i] * LIMIT_COEFF;
      ch_lim[i] = rounded_q[i] + LIMIT_OFFSET;
    end
  end

  // ==========================================================================
  // Pipeline
  // ==========================================================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      scaled_q  <= '0;
      rounded_q <= '0;
      vid_d1    <= '0;
      vid_d2    <= '0;
      video_o   <= '0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        // Top nine bits then round half up to eight
        scaled_q[i]  <= prod[i][15:7];
        rounded_q[i] <= scaled_q[i][8:1] + color_t'(scaled_q[i][0]);
      end
      vid_d1        <= video_i;
      vid_d2        <= vid_d1;
      video_o.vsync <= vid_d2.vsync;
      video_o.hsync <= vid_d2.hsync;
      video_o.de    <= vid_d2.de;
      video_o.rgb   <= limited_rgb_i ? rgb_lim : vid_d2.rgb;
    end
  end

endmodule

`default_nettype wire

// ==== hw/ppu_cfg_decode.sv ====
/*
 * Configuration decoder: registers the configuration word, expands the
 * scanline strength codes and resolves the h2v link
 */
`timescale 1ns/1ps
`default_nettype none

module ppu_cfg_decode
  import ppu_pkg::*;
(
  input  logic      VCLK_Tx,
  input  logic      nVRST_Tx,
  input  cfg_word_t cfg_i,
  output sl_cfg_t   v_sl_o,
  output sl_cfg_t   h_sl_o,
  output logic      limited_rgb_o
);

  // Add one, shift by four, subtract one
  // Code 0 gives 15, code 15 gives 255
  function automatic sl_str_t expand_str(input sl_code_t code);
    logic [8:0] step;
    step = ({5'd0, code} + 9'd1) << 4;
    return sl_str_t'(step - 9'd1);
  endfunction

  sl_code_t v_code;

  // Linked mode takes the horizontal strength for both directions
  assign v_code = cfg_i.h2v_linked ? cfg_i.h_str : cfg_i.v_str;

  // ==========================================================================
  // Settings register
  // ==========================================================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      v_sl_o        <= '0;
      h_sl_o        <= '0;
      limited_rgb_o <= 1'b0;
    end else begin
      h_sl_o.en     <= cfg_i.h_en;
      h_sl_o.str    <= expand_str(cfg_i.h_str);
      // Enable stays separate even when linked
      v_sl_o.en     <= cfg_i.v_en;
      v_sl_o.str    <= expand_str(v_code);
      limited_rgb_o <= cfg_i.limited_rgb;
    end
  end

endmodule

`default_nettype wire

// ==== hw/ppu_out_top.sv ====
/*
 * Output-clock post-processing top: configuration decoder, vertical and
 * horizontal scanline stages and the limited-range output stage
 */
`timescale 1ns/1ps
`default_nettype none

module ppu_out_top
  import ppu_pkg::*;
(
  input  logic      VCLK_Tx,
  input  logic      nVRST_Tx,
  input  cfg_word_t cfg_i,
  input  video_t    video_i,
  output video_t    video_o
);

  // Latency is OUT_LATENCY cycles in total:
  // one per scanline stage, three in the range stage

  sl_cfg_t v_sl_w;
  sl_cfg_t h_sl_w;
  logic    limited_rgb_w;
  video_t  vsl_video_w;
  video_t  hsl_video_w;

  // ==========================================================================
  // Configuration
  // ==========================================================================

  ppu_cfg_decode u_cfg_decode (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .cfg_i         (cfg_i),
    .v_sl_o        (v_sl_w),
    .h_sl_o        (h_sl_w),
    .limited_rgb_o (limited_rgb_w)
  );

  // ==========================================================================
  // Video chain
  // ==========================================================================

  // Alternate columns
  scanline_stage #(
    .VERTICAL (1'b1)
  ) u_vsl (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .video_i  (video_i),
    .sl_i     (v_sl_w),
    .video_o  (vsl_video_w)
  );

  // Alternate lines
  scanline_stage #(
    .VERTICAL (1'b0)
  ) u_hsl (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .video_i  (vsl_video_w),
    .sl_i     (h_sl_w),
    .video_o  (hsl_video_w)
  );

  limit_rgb_stage u_limit (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .video_i       (hsl_video_w),
    .limited_rgb_i (limited_rgb_w),
    .video_o       (video_o)
  );

endmodule

`default_nettype wire

// ==== hw/ppu_pkg.sv ====
/*
 * Shared types for the output-clock post-processing chain: color and
 * stream structs, scanline and configuration words, range constants
 */
`default_nettype none

package ppu_pkg;

  // ==========================================================================
  // Widths
  // ==========================================================================

  // One color channel
  typedef logic [7:0] color_t;

  // Expanded scanline strength where 255 darkens fully
  typedef logic [7:0] sl_str_t;

  // Strength code as it arrives in the configuration word
  typedef logic [3:0] sl_code_t;

  // ==========================================================================
  // Stream
  // ==========================================================================

  typedef struct packed {
    color_t r;
    color_t g;
    color_t b;
  } rgb_t;

  // Sync is active high
  typedef struct packed {
    logic vsync;
    logic hsync;
    logic de;
    rgb_t rgb;
  } video_t;

  // ==========================================================================
  // Configuration
  // ==========================================================================

  // Settings for one scanline stage
  typedef struct packed {
    logic    en;
    sl_str_t str;
  } sl_cfg_t;

  // External configuration word of 12 bits
  typedef struct packed {
    sl_code_t v_str;
    sl_code_t h_str;
    logic     limited_rgb;
    logic     h2v_linked;
    logic     v_en;
    logic     h_en;
  } cfg_word_t;

  // Limited range maps 0..255 onto 16..235
  localparam color_t LIMIT_COEFF  = 8'd220;
  localparam color_t LIMIT_OFFSET = 8'd16;

  // Cycles from top input to top output
  localparam int OUT_LATENCY = 5;

endpackage

`default_nettype wire

// ==== hw/scanline_stage.sv ====
/*
 * Scanline darkening stage with one cycle of latency.
 * VERTICAL = 1 darkens odd columns, VERTICAL = 0 darkens odd lines
 */
`timescale 1ns/1ps
`default_nettype none

module scanline_stage
  import ppu_pkg::*;
#(
  parameter bit VERTICAL = 1'b1
) (
  input  logic    VCLK_Tx,
  input  logic    nVRST_Tx,
  input  video_t  video_i,
  input  sl_cfg_t sl_i,
  output video_t  video_o
);

  // c - floor(c * str / 256) cannot go below zero
  function automatic color_t darken(input color_t c, input sl_str_t s);
    logic [15:0] prod;
    prod = c * s;
    return c - prod[15:8];
  endfunction

  // Parity of the current column or line
  logic   odd_q;
  video_t dimmed;

  // ==========================================================================
  // Position counter
  // ==========================================================================

  if (VERTICAL) begin : g_column
    // First pixel of a line is column 0
    always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
      if (!nVRST_Tx) begin
        odd_q <= 1'b0;
      end else if (!video_i.de) begin
        odd_q <= 1'b0;
      end else begin
        odd_q <= ~odd_q;
      end
    end
  end else begin : g_line
    // video_o holds last cycle's de, so a falling edge is
    // old de high with new de low
    always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
      if (!nVRST_Tx) begin
        odd_q <= 1'b0;
      end else if (video_i.vsync) begin
        odd_q <= 1'b0;
      end else if (video_o.de && !video_i.de) begin
        odd_q <= ~odd_q;
      end
    end
  end

  // ==========================================================================
  // Darkening
  // ==========================================================================

  always_comb begin
    dimmed = video_i;
    if (sl_i.en && odd_q && video_i.de) begin
      dimmed.rgb.r = darken(video_i.rgb.r, sl_i.str);
      dimmed.rgb.g = darken(video_i.rgb.g, sl_i.str);
      dimmed.rgb.b = darken(video_i.rgb.b, sl_i.str);
    end
  end

  // Sync and color share the one output register
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      video_o <= '0;
    end else begin
      video_o <= dimmed;
    end
  end

endmodule

`default_nettype wire

// ==== verification/ppu_out_checker.sv ====
/*
 * Reference model and assertions for the output-clock chain: predicts each
 * output from the input stream and compares it after the pipeline delay
 */
`timescale 1ns/1ps
`default_nettype none

module ppu_out_checker
  import ppu_pkg::*;
(
  input  logic        VCLK_Tx,
  input  logic        nVRST_Tx,
  input  cfg_word_t   cfg_i,
  input  video_t      stim_video_i,
  input  video_t      dut_video_i,
  output logic        fail_o,
  output logic [31:0] checked_o
);

  video_t      pipe [OUT_LATENCY];
  video_t      exp_now;
  video_t      exp_v;
  logic [15:0] col_cnt;
  logic [15:0] line_cnt;
  logic        prev_de;
  logic        v_dark;
  logic        h_dark;
  logic        active_seen;
  logic        failed = 1'b0;

  assign fail_o = failed;

  // ==========================================================================
  // Reference rules
  // ==========================================================================

  // Code 0 gives 15, code 15 gives 255
  function automatic int expand_code(input sl_code_t code);
    return (int'(code) + 1) * 16 - 1;
  endfunction

  function automatic color_t dim_channel(input color_t c, input int str);
    return color_t'(int'(c) - (int'(c) * str) / 256);
  endfunction

  function automatic color_t range_channel(input color_t c);
    return color_t'((int'(c) * int'(LIMIT_COEFF) + 128) / 256 + int'(LIMIT_OFFSET));
  endfunction

  // Vertical first, then horizontal, then the range rule
  function automatic color_t predict_channel(input color_t c, input logic vd,
                                             input logic hd, input cfg_word_t cfg);
    color_t val;
    val = c;
    if (vd)
      val = dim_channel(val, expand_code(cfg.h2v_linked ? cfg.h_str : cfg.v_str));
    if (hd)
      val = dim_channel(val, expand_code(cfg.h_str));
    if (cfg.limited_rgb)
      val = range_channel(val);
    return val;
  endfunction

  always_comb begin
    v_dark  = cfg_i.v_en && col_cnt[0];
    h_dark  = cfg_i.h_en && line_cnt[0];
    exp_now = stim_video_i;
    if (stim_video_i.de) begin
      exp_now.rgb.r = predict_channel(stim_video_i.rgb.r, v_dark, h_dark, cfg_i);
      exp_now.rgb.g = predict_channel(stim_video_i.rgb.g, v_dark, h_dark, cfg_i);
      exp_now.rgb.b = predict_channel(stim_video_i.rgb.b, v_dark, h_dark, cfg_i);
    end
  end

  // Position counters, the delay line of predictions and the count of
  // active pixels leaving the DUT
  always @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      for (int i = 0; i < OUT_LATENCY; i++)
        pipe[i] <= '0;
      col_cnt     <= '0;
      line_cnt    <= '0;
      prev_de     <= 1'b0;
      active_seen <= 1'b0;
      checked_o   <= '0;
    end else begin
      pipe[0] <= exp_now;
      for (int i = 1; i < OUT_LATENCY; i++)
        pipe[i] <= pipe[i-1];
      col_cnt <= stim_video_i.de ? col_cnt + 16'd1 : 16'd0;
      if (stim_video_i.vsync)
        line_cnt <= '0;
      else if (prev_de && !stim_video_i.de)
        line_cnt <= line_cnt + 16'd1;
      prev_de <= stim_video_i.de;
      if (pipe[OUT_LATENCY-1].de)
        active_seen <= 1'b1;
      if (dut_video_i.de)
        checked_o <= checked_o + 32'd1;
    end
  end

  // ==========================================================================
  // Comparison
  // ==========================================================================

  task automatic check_field(input string name, input logic [7:0] exp_val,
                             input logic [7:0] act_val);
    if (!failed) begin
      assert (act_val === exp_val)
      else begin
        $display("FAILED %s: expected 0x%02h, got 0x%02h", name, exp_val, act_val);
        failed = 1'b1;
      end
    end
  endtask

  // Color counts on active pixels and stays zero until the first one comes out
  always @(posedge VCLK_Tx) begin
    exp_v = pipe[OUT_LATENCY-1];
    check_field("video_o.vsync", 8'(exp_v.vsync), 8'(dut_video_i.vsync));
    check_field("video_o.hsync", 8'(exp_v.hsync), 8'(dut_video_i.hsync));
    check_field("video_o.de", 8'(exp_v.de), 8'(dut_video_i.de));
    if (exp_v.de || !active_seen) begin
      check_field("video_o.rgb.r", exp_v.rgb.r, dut_video_i.rgb.r);
      check_field("video_o.rgb.g", exp_v.rgb.g, dut_video_i.rgb.g);
      check_field("video_o.rgb.b", exp_v.rgb.b, dut_video_i.rgb.b);
    end
  end

endmodule

`default_nettype wire

// ==== verification/tb_ppu_out.sv ====
/*
 * Testbench for the output-clock chain: clock, reset, LFSR pixel frames
 * with one configuration per frame, DUT, checker and end of test
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ppu_out
  import ppu_pkg::*;
();

  localparam int RESET_CYCLES  = 16;
  localparam int ACTIVE_PIXELS = 16;
  localparam int BLANK_CYCLES  = 8;
  localparam int FRAME_LINES   = 4;
  localparam int DRAIN_TIMEOUT = 64;

  logic        VCLK_Tx;
  logic        nVRST_Tx;
  cfg_word_t   cfg;
  video_t      video_in;
  video_t      video_out;
  logic        chk_fail;
  logic [31:0] checked_cnt;
  logic [31:0] driven_cnt;
  logic [15:0] lfsr;
  logic        drain_ok;

  initial VCLK_Tx = 1'b0;
  always #4 VCLK_Tx = ~VCLK_Tx;

  ppu_out_top u_ppu_out_top (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .cfg_i    (cfg),
    .video_i  (video_in),
    .video_o  (video_out)
  );

  ppu_out_checker u_ppu_out_checker (
    .VCLK_Tx      (VCLK_Tx),
    .nVRST_Tx     (nVRST_Tx),
    .cfg_i        (cfg),
    .stim_video_i (video_in),
    .dut_video_i  (video_out),
    .fail_o       (chk_fail),
    .checked_o    (checked_cnt)
  );

  always @(posedge chk_fail) begin
    $display("Test FAILED");
    $fatal(1);
  end

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  // 16-bit Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0])
      return (s >> 1) ^ 16'hB400;
    return s >> 1;
  endfunction

  task automatic random_color(output color_t c);
    c = '0;
    for (int i = 0; i < 8; i++) begin
      c = {c[6:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic drive_pixel(input logic vs, input logic hs, input logic de,
                             input rgb_t rgb);
    video_t v;
    v.vsync = vs;
    v.hsync = hs;
    v.de    = de;
    v.rgb   = rgb;
    @(posedge VCLK_Tx);
    video_in <= v;
    if (de)
      driven_cnt = driven_cnt + 32'd1;
  endtask

  // Column 0 is black and column 2 is white to hit both range ends
  task automatic send_line();
    rgb_t px;
    for (int x = 0; x < ACTIVE_PIXELS; x++) begin
      if (x == 0) begin
        px = '0;
      end else if (x == 2) begin
        px = '1;
      end else begin
        random_color(px.r);
        random_color(px.g);
        random_color(px.b);
      end
      drive_pixel(1'b0, 1'b0, 1'b1, px);
    end
    for (int x = 0; x < BLANK_CYCLES; x++)
      drive_pixel(1'b0, (x >= 2 && x < 5), 1'b0, '0);
  endtask

  // New settings at the start of the vsync gap
  task automatic send_frame(input cfg_word_t frame_cfg);
    for (int x = 0; x < BLANK_CYCLES; x++) begin
      drive_pixel((x >= 1 && x < 5), 1'b0, 1'b0, '0);
      if (x == 0)
        cfg <= frame_cfg;
    end
    for (int y = 0; y < FRAME_LINES; y++)
      send_line();
  endtask

  // Bits of k pick v_en, h_en, limited_rgb and h2v_linked
  function automatic cfg_word_t make_cfg(input logic [3:0] k);
    cfg_word_t c;
    c.v_en        = k[0];
    c.h_en        = k[1];
    c.limited_rgb = k[2];
    c.h2v_linked  = k[3];
    c.v_str       = k;
    c.h_str       = ~k;
    return c;
  endfunction

  task automatic wait_drain(output logic done);
    int cycles;
    cycles = 0;
    while (checked_cnt != driven_cnt && cycles < DRAIN_TIMEOUT) begin
      @(posedge VCLK_Tx);
      cycles++;
    end
    done = (checked_cnt == driven_cnt);
  endtask

  initial begin
    nVRST_Tx   = 1'b0;
    cfg        = '0;
    video_in   = '0;
    lfsr       = 16'd91;
    driven_cnt = '0;
    drain_ok   = 1'b0;
    repeat (RESET_CYCLES) @(posedge VCLK_Tx);
    nVRST_Tx <= 1'b1;
    for (int i = 0; i < BLANK_CYCLES; i++)
      drive_pixel(1'b0, 1'b0, 1'b0, '0);
    for (int k = 0; k < 16; k++)
      send_frame(make_cfg(4'(k)));
    wait_drain(drain_ok);
    if (drain_ok) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Timeout waiting for every driven pixel to leave the DUT");
      $display("Test FAILED");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/ppu_pkg.sv
hw/ppu_cfg_decode.sv
hw/scanline_stage.sv
hw/limit_rgb_stage.sv
hw/ppu_out_top.sv
verification/ppu_out_checker.sv
verification/tb_ppu_out.sv
